//--- hw/ssio_rx_pkg.sv
// link word, wishbone and framing types, register map and link constants
package ssio_rx_pkg;

    // eight data lanes plus one valid lane
    localparam int LINK_WIDTH = 9;
    localparam logic [7:0] SYNC_BYTE = 8'hd5;
    localparam int MAX_PAYLOAD = 16;
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    // valid lane sits above the data lanes
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } link_word_t;

    typedef enum logic [2:0] {
        ST_HUNT,
        ST_LENGTH,
        ST_PAYLOAD,
        ST_CHECK,
        ST_HOLD
    } frame_state_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [5:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // framing strobes toward the payload buffer
    typedef struct packed {
        logic       wr;
        logic [3:0] idx;
        // payload or checksum byte, depending on the strobe
        logic [7:0] data;
        logic       len_load;
        logic [4:0] len;
        logic       check;
        logic       done;
        logic       drop;
    } buf_ctl_t;

    typedef enum logic [5:0] {
        REG_STATUS  = 6'd0,
        REG_CONTROL = 6'd1,
        REG_DROPS   = 6'd2,
        REG_PAYLOAD = 6'd16
    } reg_addr_e;

endpackage

//--- hw/ssio_sdr_in.sv
// single data rate capture of the lanes on the forwarded clock
`timescale 1ns/10ps
module ssio_sdr_in #(
    parameter int WIDTH = 1
) (
    input  logic             input_clk,
    input  logic [WIDTH-1:0] input_d,
    output logic             output_clk,
    output logic [WIDTH-1:0] output_q
);

    // forwarded clock drives the link domain downstream
    assign output_clk = input_clk;

    // one register stage per lane, rising edge only
    always_ff @(posedge input_clk) begin
        output_q <= input_d;
    end

endmodule

//--- hw/ssio_sdr_in_diff.sv
// differential input buffers per vendor ahead of the sdr capture stage
`timescale 1ns/10ps
module ssio_sdr_in_diff #(
    // skip vendor primitives in simulation
    parameter logic SIM    = 1'b0,
    // "GENERIC", "XILINX" or "ALTERA"
    parameter       VENDOR = "XILINX",
    parameter int   WIDTH  = 1
) (
    input  logic             input_clk_p,
    input  logic             input_clk_n,
    input  logic [WIDTH-1:0] input_d_p,
    input  logic [WIDTH-1:0] input_d_n,
    output logic             output_clk,
    output logic [WIDTH-1:0] output_q
);

    logic             input_clk;
    logic [WIDTH-1:0] input_d;

    // true side of each pair only
    assign input_clk = input_clk_p;
    assign input_d = input_d_p;

    ssio_sdr_in #(
        .WIDTH(WIDTH)
    ) sdr_in_inst (
        .input_clk(input_clk),
        .input_d(input_d),
        .output_clk(output_clk),
        .output_q(output_q)
    );

endmodule

//--- hw/rx_cdc_fifo.sv
// asynchronous link word FIFO with gray pointers and two-flop synchronizers
`timescale 1ns/10ps
module rx_cdc_fifo (
    input  logic                    wr_clk,
    input  logic                    rst_n,
    input  ssio_rx_pkg::link_word_t wr_word,
    output logic                    wr_full,
    input  logic                    clk,
    output ssio_rx_pkg::link_word_t rd_word,
    output logic                    rd_valid,
    input  logic                    rd_ready
);

    ssio_rx_pkg::link_word_t mem [ssio_rx_pkg::FIFO_DEPTH];

    logic [ssio_rx_pkg::FIFO_ADDR_W:0] wr_bin;
    logic [ssio_rx_pkg::FIFO_ADDR_W:0] wr_bin_next;
    logic [ssio_rx_pkg::FIFO_ADDR_W:0] wr_gray;
    logic [ssio_rx_pkg::FIFO_ADDR_W:0] wr_gray_rs1;
    logic [ssio_rx_pkg::FIFO_ADDR_W:0] wr_gray_rs2;
    logic [ssio_rx_pkg::FIFO_ADDR_W:0] rd_bin;
    logic [ssio_rx_pkg::FIFO_ADDR_W:0] rd_bin_next;
    logic [ssio_rx_pkg::FIFO_ADDR_W:0] rd_gray;
    logic [ssio_rx_pkg::FIFO_ADDR_W:0] rd_gray_ws1;
    logic [ssio_rx_pkg::FIFO_ADDR_W:0] rd_gray_ws2;
    logic                              wr_en;
    logic                              rd_en;

    // idle words never enter
    assign wr_en = wr_word.valid && !wr_full;
    assign wr_bin_next = wr_bin + 1'b1;
    // full when the top two gray bits differ and the rest match
    assign wr_full = wr_gray == {~rd_gray_ws2[ssio_rx_pkg::FIFO_ADDR_W -: 2],
                                 rd_gray_ws2[ssio_rx_pkg::FIFO_ADDR_W-2:0]};

    always_ff @(posedge wr_clk) begin
        if (!rst_n) begin
            wr_bin <= '0;
            wr_gray <= '0;
            rd_gray_ws1 <= '0;
            rd_gray_ws2 <= '0;
        end else begin
            rd_gray_ws1 <= rd_gray;
            rd_gray_ws2 <= rd_gray_ws1;
            if (wr_en) begin
                wr_bin <= wr_bin_next;
                wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wr_bin[ssio_rx_pkg::FIFO_ADDR_W-1:0]] <= wr_word;
        end
    end

    // read side in the system clock domain
    assign rd_valid = rd_gray != wr_gray_rs2;
    assign rd_en = rd_valid && rd_ready;
    assign rd_bin_next = rd_bin + 1'b1;
    assign rd_word = mem[rd_bin[ssio_rx_pkg::FIFO_ADDR_W-1:0]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_bin <= '0;
            rd_gray <= '0;
            wr_gray_rs1 <= '0;
            wr_gray_rs2 <= '0;
        end else begin
            wr_gray_rs1 <= wr_gray;
            wr_gray_rs2 <= wr_gray_rs1;
            if (rd_en) begin
                rd_bin <= rd_bin_next;
                rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
            end
        end
    end

    // link rate must stay below the drain rate, otherwise words are lost
    a_no_overflow: assert property (@(posedge wr_clk) disable iff (!rst_n)
        wr_word.valid |-> !wr_full);

endmodule

//--- hw/rx_word_counter.sv
// payload down-counter with write index and last byte flag
`timescale 1ns/10ps
module rx_word_counter (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load,
    input  logic [4:0] len,
    input  logic       dec,
    output logic [3:0] idx,
    output logic       last
);

    logic [4:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            idx <= '0;
        end else if (load) begin
            count <= len;
            idx <= '0;
        end else if (dec) begin
            count <= count - 5'd1;
            idx <= idx + 4'd1;
        end
    end

    // high during the final payload byte
    assign last = count == 5'd1;

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        dec |-> count != 5'd0);
    a_len_range: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> len != 5'd0 && len <= ssio_rx_pkg::MAX_PAYLOAD);

endmodule

//--- hw/rx_frame_fsm.sv
// framing FSM that hunts for sync, checks the length and drives the buffer
`timescale 1ns/10ps
module rx_frame_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ssio_rx_pkg::link_word_t rd_word,
    input  logic                    rd_valid,
    output logic                    rd_ready,
    input  logic                    cnt_last,
    input  logic [3:0]              cnt_idx,
    input  logic                    release_buf,
    output ssio_rx_pkg::buf_ctl_t   ctl,
    output logic                    cnt_load,
    output logic                    cnt_dec
);

    ssio_rx_pkg::frame_state_t state;
    ssio_rx_pkg::frame_state_t state_next;
    logic                      is_sync;
    logic                      len_ok;

    // every word is taken so back-pressure never reaches the link
    assign rd_ready = rd_valid;
    assign is_sync = rd_word.data == ssio_rx_pkg::SYNC_BYTE;
    assign len_ok = rd_word.data != 8'd0 && rd_word.data <= ssio_rx_pkg::MAX_PAYLOAD;

    always_comb begin
        ctl = '0;
        ctl.idx = cnt_idx;
        ctl.data = rd_word.data;
        ctl.len = rd_word.data[4:0];
        ctl.wr = rd_valid && state == ssio_rx_pkg::ST_PAYLOAD;
        ctl.len_load = rd_valid && state == ssio_rx_pkg::ST_LENGTH && len_ok;
        ctl.check = rd_valid && state == ssio_rx_pkg::ST_CHECK;
        ctl.done = ctl.check;
        // a sync byte while held means a lost frame
        ctl.drop = rd_valid && state == ssio_rx_pkg::ST_HOLD && is_sync;
    end

    assign cnt_load = ctl.len_load;
    assign cnt_dec = ctl.wr;

    always_comb begin
        state_next = state;
        case (state)
            ssio_rx_pkg::ST_HUNT: begin
                if (rd_valid && is_sync) state_next = ssio_rx_pkg::ST_LENGTH;
            end
            ssio_rx_pkg::ST_LENGTH: begin
                if (rd_valid) begin
                    state_next = len_ok ? ssio_rx_pkg::ST_PAYLOAD : ssio_rx_pkg::ST_HUNT;
                end
            end
            ssio_rx_pkg::ST_PAYLOAD: begin
                if (rd_valid && cnt_last) state_next = ssio_rx_pkg::ST_CHECK;
            end
            ssio_rx_pkg::ST_CHECK: begin
                if (rd_valid) state_next = ssio_rx_pkg::ST_HOLD;
            end
            ssio_rx_pkg::ST_HOLD: begin
                if (release_buf) state_next = ssio_rx_pkg::ST_HUNT;
            end
            default: state_next = ssio_rx_pkg::ST_HUNT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ssio_rx_pkg::ST_HUNT;
        end else begin
            state <= state_next;
        end
    end

    // a loaded length of 1 to 16 flags the last byte before the index wraps
    a_payload_len: assert property (@(posedge clk) disable iff (!rst_n)
        state == ssio_rx_pkg::ST_PAYLOAD && rd_valid
        && cnt_idx == 4'(ssio_rx_pkg::MAX_PAYLOAD - 1) |-> cnt_last);

endmodule

//--- hw/rx_frame_buffer.sv
// payload store, checksum, status and drop registers behind a wishbone slave
`timescale 1ns/10ps
module rx_frame_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ssio_rx_pkg::buf_ctl_t ctl,
    input  ssio_rx_pkg::wb_req_t  wb_req,
    output ssio_rx_pkg::wb_rsp_t  wb_rsp,
    output logic                  release_buf
);

    logic [7:0]  payload [ssio_rx_pkg::MAX_PAYLOAD];
    logic [7:0]  csum;
    logic [4:0]  len_q;
    logic        chk_err;
    logic        frame_ready;
    logic [7:0]  drops;
    logic        ack_q;
    logic [31:0] dat_q;
    logic [31:0] rd_data;
    logic        wb_go;

    assign wb_go = wb_req.cyc && wb_req.stb && !ack_q;
    assign wb_rsp = '{ack: ack_q, dat: dat_q};
    // host keeps the request stable through the ack cycle
    assign release_buf = ack_q && wb_req.cyc && wb_req.stb && wb_req.we
        && wb_req.adr == ssio_rx_pkg::REG_CONTROL && wb_req.dat[0];

    always_comb begin
        rd_data = '0;
        case (wb_req.adr)
            ssio_rx_pkg::REG_STATUS: rd_data = {19'd0, len_q, 6'd0, chk_err, frame_ready};
            ssio_rx_pkg::REG_DROPS: rd_data = {24'd0, drops};
            default: begin
                if (wb_req.adr >= ssio_rx_pkg::REG_PAYLOAD &&
                    wb_req.adr < ssio_rx_pkg::REG_PAYLOAD + ssio_rx_pkg::MAX_PAYLOAD) begin
                    rd_data = {24'd0, payload[wb_req.adr[3:0]]};
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctl.wr) payload[ctl.idx] <= ctl.data;
        if (wb_go) dat_q <= rd_data;
        if (ctl.len_load) csum <= '0;
        else if (ctl.wr) csum <= csum ^ ctl.data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            frame_ready <= 1'b0;
            chk_err <= 1'b0;
            len_q <= '0;
            drops <= '0;
        end else begin
            ack_q <= wb_go;
            if (ctl.len_load) begin
                len_q <= ctl.len;
                chk_err <= 1'b0;
            end
            // checksum byte against the running xor of the payload
            if (ctl.check) chk_err <= csum != ctl.data;
            if (ctl.done) frame_ready <= 1'b1;
            else if (release_buf) frame_ready <= 1'b0;
            if (ctl.drop && drops != 8'hff) drops <= drops + 8'd1;
        end
    end

    a_held_intact: assert property (@(posedge clk) disable iff (!rst_n)
        frame_ready |-> !ctl.wr && !ctl.len_load);

endmodule

//--- hw/ssio_rx_top.sv
// receive link top with input stage, cdc FIFO, framing FSM, counter and buffer
`timescale 1ns/10ps
module ssio_rx_top #(
    parameter logic SIM    = 1'b0,
    parameter       VENDOR = "XILINX"
) (
    input  logic                               input_clk_p,
    input  logic                               input_clk_n,
    input  logic [ssio_rx_pkg::LINK_WIDTH-1:0] input_d_p,
    input  logic [ssio_rx_pkg::LINK_WIDTH-1:0] input_d_n,
    input  logic                               clk,
    input  logic                               rst_n,
    input  ssio_rx_pkg::wb_req_t               wb_req,
    output ssio_rx_pkg::wb_rsp_t               wb_rsp
);

    logic                    link_clk;
    ssio_rx_pkg::link_word_t cap_word;
    ssio_rx_pkg::link_word_t rd_word;
    logic                    rd_valid;
    logic                    rd_ready;
    ssio_rx_pkg::buf_ctl_t   buf_ctl;
    logic                    cnt_load;
    logic                    cnt_dec;
    logic [3:0]              cnt_idx;
    logic                    cnt_last;
    logic                    release_buf;

    ssio_sdr_in_diff #(
        .SIM(SIM),
        .VENDOR(VENDOR),
        .WIDTH(ssio_rx_pkg::LINK_WIDTH)
    ) sdr_in_diff_inst (
        .input_clk_p(input_clk_p),
        .input_clk_n(input_clk_n),
        .input_d_p(input_d_p),
        .input_d_n(input_d_n),
        .output_clk(link_clk),
        .output_q(cap_word)
    );

    rx_cdc_fifo fifo_inst (
        .wr_clk(link_clk),
        .rst_n(rst_n),
        .wr_word(cap_word),
        .wr_full(),
        .clk(clk),
        .rd_word(rd_word),
        .rd_valid(rd_valid),
        .rd_ready(rd_ready)
    );

    rx_frame_fsm fsm_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rd_word(rd_word),
        .rd_valid(rd_valid),
        .rd_ready(rd_ready),
        .cnt_last(cnt_last),
        .cnt_idx(cnt_idx),
        .release_buf(release_buf),
        .ctl(buf_ctl),
        .cnt_load(cnt_load),
        .cnt_dec(cnt_dec)
    );

    rx_word_counter counter_inst (
        .clk(clk),
        .rst_n(rst_n),
        .load(cnt_load),
        .len(buf_ctl.len),
        .dec(cnt_dec),
        .idx(cnt_idx),
        .last(cnt_last)
    );

    rx_frame_buffer buffer_inst (
        .clk(clk),
        .rst_n(rst_n),
        .ctl(buf_ctl),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .release_buf(release_buf)
    );

endmodule

//--- test/tb_ssio_rx.sv
// testbench for the receive link with frame transmitter, wishbone host, reference model, checks
`timescale 1ns/10ps
module tb_ssio_rx;

    localparam int RANDOM_FRAMES = 20;
    localparam int DROP_FRAMES = 3;
    // 40 frames at 200 clk cycles each
    localparam int TIMEOUT_CYCLES = 40 * 200;
    localparam int POLL_LIMIT = 50;
    localparam int ACK_LIMIT = 8;

    logic                               clk;
    logic                               rst_n;
    logic                               input_clk_p;
    logic                               input_clk_n;
    logic [ssio_rx_pkg::LINK_WIDTH-1:0] input_d_p;
    logic [ssio_rx_pkg::LINK_WIDTH-1:0] input_d_n;
    ssio_rx_pkg::wb_req_t               wb_req;
    ssio_rx_pkg::wb_rsp_t               wb_rsp;
    ssio_rx_pkg::wb_rsp_t               host_rsp;

    logic [31:0] rng;
    logic [7:0]  frame_data [ssio_rx_pkg::MAX_PAYLOAD];
    logic [7:0]  held_data [ssio_rx_pkg::MAX_PAYLOAD];
    int          frame_len;
    int          held_len;
    logic [7:0]  frame_csum;
    logic [7:0]  held_csum;
    int          exp_drops;
    int          cycles;
    int          status_errors;
    int          byte_errors;
    int          drop_errors;
    int          other_errors;

    ssio_rx_top #(
        .SIM(1'b1)
    ) dut_i (
        .input_clk_p(input_clk_p),
        .input_clk_n(input_clk_n),
        .input_d_p(input_d_p),
        .input_d_n(input_d_n),
        .clk(clk),
        .rst_n(rst_n),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

    always #5 clk = ~clk;
    // forwarded link clock runs slower than clk so the FIFO drains
    always #6 input_clk_p = ~input_clk_p;
    assign input_clk_n = ~input_clk_p;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped: test did not finish within %0d clk cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] payload_xor(input int len);
        logic [7:0] acc;
        acc = 8'd0;
        for (int k = 0; k < len; k++) acc = acc ^ frame_data[k];
        return acc;
    endfunction

    // expected REG_STATUS with ready in bit 0, checksum error in bit 1, length in bits 12:8
    function automatic logic [31:0] status_word(input logic ready, input logic err, input int len);
        return {19'd0, len[4:0], 6'd0, err, ready};
    endfunction

    // each sync byte seen while held counts as one dropped frame
    function automatic int sync_count(input int len, input logic [7:0] csum);
        int n;
        n = 1;
        for (int k = 0; k < len; k++) if (frame_data[k] == ssio_rx_pkg::SYNC_BYTE) n++;
        if (csum == ssio_rx_pkg::SYNC_BYTE) n++;
        return n;
    endfunction

    function automatic int saturate_drops(input int prev, input int added);
        return (prev + added > 255) ? 255 : prev + added;
    endfunction

    task automatic check_status(input logic [31:0] expected, input ssio_rx_pkg::wb_rsp_t rsp);
        if (rsp.dat !== expected) begin
            status_errors++;
            $display("Error at %0t: REG_STATUS expected %08h, got %08h", $time, expected, rsp.dat);
        end
    endtask

    task automatic check_byte(input int k, input logic [7:0] expected,
                              input ssio_rx_pkg::wb_rsp_t rsp);
        if (rsp.dat !== {24'd0, expected}) begin
            byte_errors++;
            $display("Error at %0t: payload[%0d] expected %02h, got %08h",
                     $time, k, expected, rsp.dat);
        end
    endtask

    task automatic check_drops(input logic [7:0] expected, input ssio_rx_pkg::wb_rsp_t rsp);
        if (rsp.dat !== {24'd0, expected}) begin
            drop_errors++;
            $display("Error at %0t: REG_DROPS expected %02h, got %08h", $time, expected, rsp.dat);
        end
    endtask

    task automatic wb_access(input logic we, input logic [5:0] adr, input logic [31:0] wdat,
                             output ssio_rx_pkg::wb_rsp_t rsp);
        ssio_rx_pkg::wb_req_t req;
        int n;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we = we;
        req.adr = adr;
        req.dat = wdat;
        rsp = '0;
        n = 0;
        @(posedge clk);
        wb_req <= req;
        do begin
            @(posedge clk);
            n++;
        end while (!wb_rsp.ack && n < ACK_LIMIT);
        if (wb_rsp.ack) begin
            rsp = wb_rsp;
        end else begin
            other_errors++;
            $display("Wishbone access to address %0d was never acknowledged", adr);
        end
        wb_req <= '0;
    endtask

    task automatic read_reg(input logic [5:0] adr, output ssio_rx_pkg::wb_rsp_t rsp);
        wb_access(1'b0, adr, 32'd0, rsp);
    endtask

    task automatic release_buffer;
        ssio_rx_pkg::wb_rsp_t rsp;
        wb_access(1'b1, ssio_rx_pkg::REG_CONTROL, 32'd1, rsp);
    endtask

    task automatic send_word(input logic valid, input logic [7:0] data);
        ssio_rx_pkg::link_word_t w;
        w.valid = valid;
        w.data = data;
        @(posedge input_clk_p);
        input_d_p <= w;
        input_d_n <= ~w;
    endtask

    // idle words and non-sync noise closed by one more idle word
    task automatic send_gap;
        int idles;
        int junk;
        logic [7:0] b;
        rng = xorshift32(rng);
        idles = int'(rng[1:0]);
        junk = int'(rng[3:2]);
        repeat (idles) send_word(1'b0, 8'h00);
        repeat (junk) begin
            rng = xorshift32(rng);
            b = rng[7:0];
            if (b == ssio_rx_pkg::SYNC_BYTE) b = ~b;
            send_word(1'b1, b);
        end
        send_word(1'b0, 8'h00);
    endtask

    task automatic random_frame;
        rng = xorshift32(rng);
        frame_len = int'(rng[3:0]) + 1;
        for (int k = 0; k < frame_len; k++) begin
            rng = xorshift32(rng);
            frame_data[k] = rng[7:0];
        end
        frame_csum = payload_xor(frame_len);
    endtask

    task automatic send_frame;
        send_word(1'b1, ssio_rx_pkg::SYNC_BYTE);
        send_word(1'b1, frame_len[7:0]);
        for (int k = 0; k < frame_len; k++) send_word(1'b1, frame_data[k]);
        send_word(1'b1, frame_csum);
        send_word(1'b0, 8'h00);
    endtask

    task automatic wait_ready(output logic ok);
        ssio_rx_pkg::wb_rsp_t rsp;
        int n;
        ok = 1'b0;
        n = 0;
        while (!ok && n < POLL_LIMIT) begin
            read_reg(ssio_rx_pkg::REG_STATUS, rsp);
            ok = rsp.dat[0];
            n++;
        end
        if (!ok) begin
            other_errors++;
            $display("frame_ready did not rise within %0d status polls", POLL_LIMIT);
        end
    endtask

    task automatic check_received;
        ssio_rx_pkg::wb_rsp_t rsp;
        logic ok;
        wait_ready(ok);
        if (ok) begin
            read_reg(ssio_rx_pkg::REG_STATUS, rsp);
            check_status(status_word(1'b1, frame_csum != payload_xor(frame_len), frame_len), rsp);
            for (int k = 0; k < frame_len; k++) begin
                read_reg(6'(ssio_rx_pkg::REG_PAYLOAD + k), rsp);
                check_byte(k, frame_data[k], rsp);
            end
        end
    endtask

    task automatic wait_drops(input int expected);
        ssio_rx_pkg::wb_rsp_t rsp;
        int n;
        n = 0;
        do begin
            read_reg(ssio_rx_pkg::REG_DROPS, rsp);
            n++;
        end while (rsp.dat[7:0] != expected[7:0] && n < POLL_LIMIT);
        check_drops(expected[7:0], rsp);
    endtask

    initial begin
        clk = 1'b0;
        input_clk_p = 1'b0;
        rst_n = 1'b0;
        input_d_p = '0;
        input_d_n = '1;
        wb_req = '0;
        rng = 32'hfd0b_a5e0;
        exp_drops = 0;
        cycles = 0;
        status_errors = 0;
        byte_errors = 0;
        drop_errors = 0;
        other_errors = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        read_reg(ssio_rx_pkg::REG_STATUS, host_rsp);
        check_status(status_word(1'b0, 1'b0, 0), host_rsp);
        read_reg(ssio_rx_pkg::REG_DROPS, host_rsp);
        check_drops(8'd0, host_rsp);

        for (int i = 0; i < RANDOM_FRAMES; i++) begin
            send_gap();
            random_frame();
            send_frame();
            check_received();
            release_buffer();
        end

        // flipped checksum byte must leave the payload intact
        random_frame();
        frame_csum = frame_csum ^ 8'h5a;
        send_frame();
        check_received();
        release_buffer();

        // out-of-range lengths send the FSM back to hunting
        send_word(1'b1, ssio_rx_pkg::SYNC_BYTE);
        send_word(1'b1, 8'd0);
        send_word(1'b1, ssio_rx_pkg::SYNC_BYTE);
        send_word(1'b1, 8'd17);
        send_word(1'b0, 8'h00);
        repeat (4) begin
            read_reg(ssio_rx_pkg::REG_STATUS, host_rsp);
            check_status(status_word(1'b0, frame_csum != payload_xor(frame_len), frame_len),
                         host_rsp);
        end
        random_frame();
        send_frame();
        check_received();
        release_buffer();

        // frames arriving while the buffer is held
        random_frame();
        send_frame();
        check_received();
        for (int k = 0; k < ssio_rx_pkg::MAX_PAYLOAD; k++) held_data[k] = frame_data[k];
        held_len = frame_len;
        held_csum = frame_csum;
        for (int i = 0; i < DROP_FRAMES; i++) begin
            send_gap();
            random_frame();
            send_frame();
            exp_drops = saturate_drops(exp_drops, sync_count(frame_len, frame_csum));
        end
        wait_drops(exp_drops);
        for (int k = 0; k < ssio_rx_pkg::MAX_PAYLOAD; k++) frame_data[k] = held_data[k];
        frame_len = held_len;
        frame_csum = held_csum;
        check_received();
        // drop count must have settled, not just passed through the expected value
        read_reg(ssio_rx_pkg::REG_DROPS, host_rsp);
        check_drops(exp_drops[7:0], host_rsp);
        release_buffer();
        send_gap();
        random_frame();
        send_frame();
        check_received();
        release_buffer();

        $display("errors: status %0d, payload %0d, drops %0d, other %0d",
                 status_errors, byte_errors, drop_errors, other_errors);
        if (status_errors + byte_errors + drop_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
hw/ssio_rx_pkg.sv
hw/ssio_sdr_in.sv
hw/ssio_sdr_in_diff.sv
hw/rx_cdc_fifo.sv
hw/rx_word_counter.sv
hw/rx_frame_fsm.sv
hw/rx_frame_buffer.sv
hw/ssio_rx_top.sv
test/tb_ssio_rx.sv

//--- Bender.yml
package:
  name: ssio_rx

dependencies: {}

sources:
  - files:
      - hw/ssio_rx_pkg.sv
      - hw/ssio_sdr_in.sv
      - hw/ssio_sdr_in_diff.sv
      - hw/rx_cdc_fifo.sv
      - hw/rx_word_counter.sv
      - hw/rx_frame_fsm.sv
      - hw/rx_frame_buffer.sv
      - hw/ssio_rx_top.sv
  - target: test
    files:
      - test/tb_ssio_rx.sv
